//--- rtl/pet_bus_macros.svh
// ************************************************************************
// PET host bus macros
// Bus widths, peripheral windows and the Wishbone timeout limit
// ************************************************************************
`ifndef PET_BUS_MACROS_SVH
`define PET_BUS_MACROS_SVH

// Wishbone address and data widths
`define WB_ADDR_WIDTH 8
`define DATA_WIDTH 8

// Character RAM window
`define RAM_BASE 8'h00
`define RAM_DEPTH 64

// Control register window
`define REG_BASE 8'h80
`define REG_COUNT 2

// Cycles a bus cycle may wait for an acknowledge
`define WB_TIMEOUT_CYCLES 8

`endif

//--- rtl/wb_pkg.sv
// ************************************************************************
// Wishbone bus types
// Address and data words plus the bus master state encoding
// ************************************************************************
`include "pet_bus_macros.svh"

package wb_pkg;

    // One address on the internal bus
    typedef logic [`WB_ADDR_WIDTH-1:0] wb_addr_t;

    // One data word, shared by every peripheral
    typedef logic [`DATA_WIDTH-1:0] wb_data_t;

    // Bus master states
    // Idle waits for a command, request drives the strobe,
    // wait_ack holds the cycle open, respond pulses the response
    typedef enum logic [1:0] {
        BUS_IDLE     = 2'd0,
        BUS_REQUEST  = 2'd1,
        BUS_WAIT_ACK = 2'd2,
        BUS_RESPOND  = 2'd3
    } bus_state_t;

endpackage

//--- rtl/pet_reg_pkg.sv
// ************************************************************************
// PET control register definitions
// Register indices, bit positions and power-on values
// ************************************************************************
package pet_reg_pkg;

    // Index into the register file, low address bit
    typedef logic [0:0] reg_addr_t;

    localparam reg_addr_t REG_CPU   = 1'b0;
    localparam reg_addr_t REG_VIDEO = 1'b1;

    // CPU register bits
    localparam int unsigned REG_CPU_READY_BIT = 0;
    localparam int unsigned REG_CPU_RESET_BIT = 1;

    // Video register bits
    localparam int unsigned REG_VIDEO_COL_80_BIT   = 0;
    localparam int unsigned REG_VIDEO_GRAPHICS_BIT = 1;

    // RAM mask field, two bits from bit 2
    localparam int unsigned REG_VIDEO_MASK_LSB   = 2;
    localparam int unsigned REG_VIDEO_MASK_WIDTH = 2;

    // CPU held in reset and not ready at power on
    localparam wb_pkg::wb_data_t CPU_POWER_ON = 8'b0000_0010;

    // 40 columns, graphics, no RAM mask
    localparam wb_pkg::wb_data_t VIDEO_POWER_ON = 8'h00;

endpackage

//--- rtl/wb_decode.sv
// ************************************************************************
// Wishbone address decoder
// Flags addresses inside the window BASE to BASE+SPAN-1
// ************************************************************************
`timescale 1ns/100ps

module wb_decode #(
    parameter wb_pkg::wb_addr_t BASE = '0,
    parameter int unsigned      SPAN = 1
) (
    input  wb_pkg::wb_addr_t wb_addr_i,
    output logic             selected_o
);
    // Window bounds, widened so BASE+SPAN cannot wrap
    localparam int unsigned LOW  = 32'(BASE);
    localparam int unsigned HIGH = LOW + SPAN;

    logic [31:0] addr_ext;

    // Zero-extend the bus address to compare against the bounds
    assign addr_ext = 32'(wb_addr_i);

    // Upper bound is exclusive
    assign selected_o = (addr_ext >= LOW) && (addr_ext < HIGH);
endmodule

//--- rtl/wb_timeout_timer.sv
// ************************************************************************
// Wishbone timeout timer
// Flags a bus cycle that stays open without acknowledge too long
// ************************************************************************
`timescale 1ns/100ps
`include "pet_bus_macros.svh"

module wb_timeout_timer (
    input  logic wb_clock_i,
    input  logic arst_n_i,
    input  logic wb_cycle_i,
    output logic expired_o
);
    localparam int unsigned CNT_W = $clog2(`WB_TIMEOUT_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_LIMIT = CNT_W'(`WB_TIMEOUT_CYCLES);

    logic [CNT_W-1:0] count_q;

    // Count clocks of an open cycle, saturating at the limit
    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q <= '0;
        end else if (!wb_cycle_i) begin
            // Cycle closed, start over for the next one
            count_q <= '0;
        end else if (!expired_o) begin
            count_q <= count_q + 1'b1;
        end
    end

    // Held high until the master closes the cycle
    assign expired_o = (count_q == CNT_LIMIT);
endmodule

//--- rtl/bus_master_fsm.sv
// ************************************************************************
// Wishbone bus master
// Turns single-cycle command strobes into Wishbone B4 pipelined cycles
// and returns one response strobe per command
// ************************************************************************
`timescale 1ns/100ps

module bus_master_fsm (
    input  logic             wb_clock_i,
    input  logic             arst_n_i,

    // Command port from the outside bridge
    input  logic             cmd_valid_i,
    input  logic             cmd_we_i,
    input  wb_pkg::wb_addr_t cmd_addr_i,
    input  wb_pkg::wb_data_t cmd_data_i,

    // Wishbone master side
    output logic             wb_cycle_o,
    output logic             wb_strobe_o,
    output logic             wb_we_o,
    output wb_pkg::wb_addr_t wb_addr_o,
    output wb_pkg::wb_data_t wb_data_o,
    input  logic             wb_ack_i,
    input  wb_pkg::wb_data_t wb_data_i,

    // From the timeout timer
    input  logic             timeout_i,

    // Response port back to the bridge
    output logic             rsp_valid_o,
    output wb_pkg::wb_data_t rsp_data_o,
    output logic             rsp_err_o
);
    wb_pkg::bus_state_t state_q;

    // State register
    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= wb_pkg::BUS_IDLE;
            rsp_err_o <= 1'b0;
        end else begin
            case (state_q)
                wb_pkg::BUS_IDLE: begin
                    // Commands outside idle are dropped, no back-pressure
                    if (cmd_valid_i) begin
                        state_q <= wb_pkg::BUS_REQUEST;
                    end
                end
                wb_pkg::BUS_REQUEST: begin
                    // Strobe lasts exactly this one cycle
                    state_q <= wb_pkg::BUS_WAIT_ACK;
                end
                wb_pkg::BUS_WAIT_ACK: begin
                    if (wb_ack_i || timeout_i) begin
                        state_q   <= wb_pkg::BUS_RESPOND;
                        // Acknowledge wins if both land together
                        rsp_err_o <= !wb_ack_i;
                    end
                end
                default: begin
                    state_q <= wb_pkg::BUS_IDLE;
                end
            endcase
        end
    end

    // Latch the command while idle
    always_ff @(posedge wb_clock_i) begin
        if (state_q == wb_pkg::BUS_IDLE && cmd_valid_i) begin
            wb_we_o   <= cmd_we_i;
            wb_addr_o <= cmd_addr_i;
            wb_data_o <= cmd_data_i;
        end
    end

    // Capture read data, or zero when the cycle timed out
    always_ff @(posedge wb_clock_i) begin
        if (state_q == wb_pkg::BUS_WAIT_ACK) begin
            if (wb_ack_i) begin
                rsp_data_o <= wb_data_i;
            end else if (timeout_i) begin
                rsp_data_o <= '0;
            end
        end
    end

    // Cycle open from request until the acknowledge or timeout is seen
    assign wb_cycle_o  = (state_q == wb_pkg::BUS_REQUEST) || (state_q == wb_pkg::BUS_WAIT_ACK);
    assign wb_strobe_o = (state_q == wb_pkg::BUS_REQUEST);

    // One-cycle response strobe
    assign rsp_valid_o = (state_q == wb_pkg::BUS_RESPOND);
endmodule

//--- rtl/register_file.sv
// ************************************************************************
// PET control register file
// Wishbone peripheral holding the CPU and video control registers,
// with the graphics status bit refreshed between accesses
// ************************************************************************
`timescale 1ns/100ps
`include "pet_bus_macros.svh"

module register_file (
    input  logic             wb_clock_i,
    input  logic             arst_n_i,

    // Wishbone B4 peripheral
    input  wb_pkg::wb_addr_t wb_addr_i,
    input  wb_pkg::wb_data_t wb_data_i,
    output wb_pkg::wb_data_t wb_data_o,
    input  logic             wb_we_i,
    input  logic             wb_cycle_i,
    input  logic             wb_strobe_i,
    output logic             wb_stall_o,
    output logic             wb_ack_o,

    // CPU register
    output logic             cpu_ready_o,
    output logic             cpu_reset_o,

    // Video register, graphics level from the VIA (0 = graphics)
    input  logic             video_graphic_i,
    output logic             video_col_80_mode_o,
    output logic [11:10]     video_ram_mask_o
);
    wb_pkg::wb_data_t      cpu_reg;
    wb_pkg::wb_data_t      video_reg;
    logic                  wb_select;
    logic                  access;
    pet_reg_pkg::reg_addr_t reg_addr;

    wb_decode #(
        .BASE(`REG_BASE),
        .SPAN(`REG_COUNT)
    ) u_decode (
        .wb_addr_i (wb_addr_i),
        .selected_o(wb_select)
    );

    // Strobe qualified by our own window
    assign access   = wb_select && wb_cycle_i && wb_strobe_i;
    assign reg_addr = wb_addr_i[0];

    // Register writes and status refresh
    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cpu_reg   <= pet_reg_pkg::CPU_POWER_ON;
            video_reg <= pet_reg_pkg::VIDEO_POWER_ON;
        end else if (access) begin
            if (wb_we_i) begin
                if (reg_addr == pet_reg_pkg::REG_CPU) begin
                    cpu_reg <= wb_data_i;
                end else begin
                    video_reg <= wb_data_i;
                end
            end
        end else begin
            // Refresh status between accesses, overwrites do not survive
            video_reg[pet_reg_pkg::REG_VIDEO_GRAPHICS_BIT] <= video_graphic_i;
        end
    end

    // Read returns the value before a write on the same edge
    always_ff @(posedge wb_clock_i) begin
        if (access) begin
            wb_data_o <= (reg_addr == pet_reg_pkg::REG_CPU) ? cpu_reg : video_reg;
        end
    end

    // One acknowledge per selected strobe
    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= access;
        end
    end

    assign wb_stall_o = 1'b0;

    assign cpu_ready_o         = cpu_reg[pet_reg_pkg::REG_CPU_READY_BIT];
    assign cpu_reset_o         = cpu_reg[pet_reg_pkg::REG_CPU_RESET_BIT];
    assign video_col_80_mode_o = video_reg[pet_reg_pkg::REG_VIDEO_COL_80_BIT];
    // Mask field drives address bits 11:10 of video RAM
    assign video_ram_mask_o    = video_reg[pet_reg_pkg::REG_VIDEO_MASK_LSB +:
                                           pet_reg_pkg::REG_VIDEO_MASK_WIDTH];
endmodule

//--- rtl/char_ram.sv
// ************************************************************************
// Character RAM scratch block
// Small synchronous Wishbone memory with a registered acknowledge
// ************************************************************************
`timescale 1ns/100ps
`include "pet_bus_macros.svh"

module char_ram (
    input  logic             wb_clock_i,
    input  logic             arst_n_i,

    // Wishbone B4 peripheral
    input  wb_pkg::wb_addr_t wb_addr_i,
    input  wb_pkg::wb_data_t wb_data_i,
    output wb_pkg::wb_data_t wb_data_o,
    input  logic             wb_we_i,
    input  logic             wb_cycle_i,
    input  logic             wb_strobe_i,
    output logic             wb_stall_o,
    output logic             wb_ack_o
);
    localparam int unsigned IDX_W = $clog2(`RAM_DEPTH);

    wb_pkg::wb_data_t mem [`RAM_DEPTH];
    logic             wb_select;
    logic             access;
    logic [IDX_W-1:0] word_idx;

    wb_decode #(
        .BASE(`RAM_BASE),
        .SPAN(`RAM_DEPTH)
    ) u_decode (
        .wb_addr_i (wb_addr_i),
        .selected_o(wb_select)
    );

    assign access   = wb_select && wb_cycle_i && wb_strobe_i;
    assign word_idx = wb_addr_i[IDX_W-1:0];

    // Read-then-write memory port, contents survive reset
    always_ff @(posedge wb_clock_i) begin
        if (access) begin
            wb_data_o <= mem[word_idx];
            if (wb_we_i) begin
                mem[word_idx] <= wb_data_i;
            end
        end
    end

    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= access;
        end
    end

    assign wb_stall_o = 1'b0;
endmodule

//--- rtl/pet_sys_bus.sv
// ************************************************************************
// PET host control bus
// Bus master, timeout timer and the two Wishbone peripherals
// ************************************************************************
`timescale 1ns/100ps
`include "pet_bus_macros.svh"

module pet_sys_bus (
    input  logic             wb_clock_i,
    input  logic             arst_n_i,

    // Command and response ports
    input  logic             cmd_valid_i,
    input  logic             cmd_we_i,
    input  wb_pkg::wb_addr_t cmd_addr_i,
    input  wb_pkg::wb_data_t cmd_data_i,
    output logic             rsp_valid_o,
    output wb_pkg::wb_data_t rsp_data_o,
    output logic             rsp_err_o,

    // Control outputs and status input
    input  logic             video_graphic_i,
    output logic             cpu_ready_o,
    output logic             cpu_reset_o,
    output logic             video_col_80_mode_o,
    output logic [11:10]     video_ram_mask_o
);
    logic             wb_cyc;
    logic             wb_stb;
    logic             wb_we;
    wb_pkg::wb_addr_t wb_addr;
    wb_pkg::wb_data_t wb_wdata;
    wb_pkg::wb_data_t wb_rdata;
    logic             wb_ack;
    logic             timeout;
    logic             reg_ack;
    logic             ram_ack;
    wb_pkg::wb_data_t reg_rdata;
    wb_pkg::wb_data_t ram_rdata;

    bus_master_fsm u_master (
        .wb_clock_i (wb_clock_i),
        .arst_n_i   (arst_n_i),
        .cmd_valid_i(cmd_valid_i),
        .cmd_we_i   (cmd_we_i),
        .cmd_addr_i (cmd_addr_i),
        .cmd_data_i (cmd_data_i),
        .wb_cycle_o (wb_cyc),
        .wb_strobe_o(wb_stb),
        .wb_we_o    (wb_we),
        .wb_addr_o  (wb_addr),
        .wb_data_o  (wb_wdata),
        .wb_ack_i   (wb_ack),
        .wb_data_i  (wb_rdata),
        .timeout_i  (timeout),
        .rsp_valid_o(rsp_valid_o),
        .rsp_data_o (rsp_data_o),
        .rsp_err_o  (rsp_err_o)
    );

    wb_timeout_timer u_timer (
        .wb_clock_i(wb_clock_i),
        .arst_n_i  (arst_n_i),
        .wb_cycle_i(wb_cyc),
        .expired_o (timeout)
    );

    // Stall outputs stay open, the master never waits on them
    register_file u_regs (
        .wb_clock_i         (wb_clock_i),
        .arst_n_i           (arst_n_i),
        .wb_addr_i          (wb_addr),
        .wb_data_i          (wb_wdata),
        .wb_data_o          (reg_rdata),
        .wb_we_i            (wb_we),
        .wb_cycle_i         (wb_cyc),
        .wb_strobe_i        (wb_stb),
        .wb_stall_o         (),
        .wb_ack_o           (reg_ack),
        .cpu_ready_o        (cpu_ready_o),
        .cpu_reset_o        (cpu_reset_o),
        .video_graphic_i    (video_graphic_i),
        .video_col_80_mode_o(video_col_80_mode_o),
        .video_ram_mask_o   (video_ram_mask_o)
    );

    char_ram u_ram (
        .wb_clock_i (wb_clock_i),
        .arst_n_i   (arst_n_i),
        .wb_addr_i  (wb_addr),
        .wb_data_i  (wb_wdata),
        .wb_data_o  (ram_rdata),
        .wb_we_i    (wb_we),
        .wb_cycle_i (wb_cyc),
        .wb_strobe_i(wb_stb),
        .wb_stall_o (),
        .wb_ack_o   (ram_ack)
    );

    // Only the addressed peripheral acknowledges
    assign wb_ack = reg_ack | ram_ack;

    // Each acknowledge marks its own read data as valid
    assign wb_rdata = ({`DATA_WIDTH{reg_ack}} & reg_rdata)
                    | ({`DATA_WIDTH{ram_ack}} & ram_rdata);
endmodule

//--- sim/pet_sys_bus_checker.sv
// ************************************************************************
// Bus master handshake checker
// Concurrent assertions on strobe length, command timing and the
// time from an open bus cycle to its response
// ************************************************************************
`timescale 1ns/100ps
`include "pet_bus_macros.svh"

module pet_sys_bus_checker (
    input logic wb_clock_i,
    input logic arst_n_i,
    input logic cmd_valid_i,
    input logic wb_cycle_i,
    input logic wb_strobe_i,
    input logic rsp_valid_i
);
    // Command edge to response, worst case through the timeout
    localparam int unsigned MAX_WAIT = `WB_TIMEOUT_CYCLES + 3;

    // Failed assertions so far, read by the testbench
    int unsigned fail_count = 0;
    int unsigned wait_cycles;

    // Clocks spent with the cycle open, cleared by the response
    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wait_cycles <= 0;
        end else if (rsp_valid_i) begin
            wait_cycles <= 0;
        end else if (wb_cycle_i) begin
            wait_cycles <= wait_cycles + 1;
        end
    end

    // Pipelined strobe covers exactly one clock
    strobe_one_cycle: assert property (
        @(posedge wb_clock_i) disable iff (!arst_n_i)
        wb_strobe_i |=> !wb_strobe_i
    ) else begin
        $error("Wishbone strobe held longer than one cycle");
        fail_count++;
    end

    // Bridge only sends while the master is idle
    command_in_idle: assert property (
        @(posedge wb_clock_i) disable iff (!arst_n_i)
        cmd_valid_i |-> (!wb_cycle_i && !rsp_valid_i)
    ) else begin
        $error("Command strobe arrived while the bus master was busy");
        fail_count++;
    end

    // A closing cycle is followed straight away by the response
    cycle_ends_in_response: assert property (
        @(posedge wb_clock_i) disable iff (!arst_n_i)
        $fell(wb_cycle_i) |-> rsp_valid_i
    ) else begin
        $error("Bus cycle closed without a response strobe");
        fail_count++;
    end

    // Bounded wait, also on an unmapped address
    response_in_time: assert property (
        @(posedge wb_clock_i) disable iff (!arst_n_i)
        wait_cycles <= MAX_WAIT
    ) else begin
        $error("Bus cycle open longer than the timeout allows");
        fail_count++;
    end
endmodule

bind bus_master_fsm pet_sys_bus_checker u_checker (
    .wb_clock_i (wb_clock_i),
    .arst_n_i   (arst_n_i),
    .cmd_valid_i(cmd_valid_i),
    .wb_cycle_i (wb_cycle_o),
    .wb_strobe_i(wb_strobe_o),
    .rsp_valid_i(rsp_valid_o)
);

//--- sim/pet_sys_bus_tb.sv
// ************************************************************************
// PET host control bus testbench
// Table-driven command sequence with response, latency and pin checks
// ************************************************************************
`timescale 1ns/100ps
`include "pet_bus_macros.svh"

module pet_sys_bus_tb;
    localparam int unsigned NUM_STEPS      = 23;
    localparam int unsigned STEP_CYCLES    = `WB_TIMEOUT_CYCLES + 6;
    localparam int unsigned MAPPED_LATENCY = 3;
    localparam int unsigned MAX_LATENCY    = `WB_TIMEOUT_CYCLES + 3;
    // Reset plus every step at its longest, with some margin
    localparam int unsigned CYCLE_LIMIT    = (NUM_STEPS + 1) * STEP_CYCLES + 20;

    // Pins as ready, reset, col 80, mask[1:0]
    localparam logic [4:0] PINS_RESET = 5'b01000;
    localparam logic [4:0] PINS_CPU   = 5'b10000;
    localparam logic [4:0] PINS_VID_A = 5'b10111;
    localparam logic [4:0] PINS_VID_B = 5'b10001;

    typedef struct packed {
        logic             we;
        wb_pkg::wb_addr_t addr;
        wb_pkg::wb_data_t data;
        logic             graphic;
        logic             chk_data;
        wb_pkg::wb_data_t exp_data;
        logic             exp_err;
        logic [4:0]       exp_pins;
    } step_t;

    logic             wb_clock_i;
    logic             arst_n_i;
    logic             cmd_valid_i;
    logic             cmd_we_i;
    wb_pkg::wb_addr_t cmd_addr_i;
    wb_pkg::wb_data_t cmd_data_i;
    logic             video_graphic_i;
    logic             rsp_valid_o;
    wb_pkg::wb_data_t rsp_data_o;
    logic             rsp_err_o;
    logic             cpu_ready_o;
    logic             cpu_reset_o;
    logic             video_col_80_mode_o;
    logic [11:10]     video_ram_mask_o;

    step_t            steps [NUM_STEPS];
    string            step_names [NUM_STEPS];
    int               step_count;
    wb_pkg::wb_addr_t ram_addr [4];
    wb_pkg::wb_data_t ram_data [4];
    integer           seed;
    int unsigned      error_count;
    int unsigned      errors_before;
    int unsigned      tests_passed;
    int unsigned      tests_failed;
    int unsigned      cycle_count;
    int unsigned      latency;
    logic             seen;
    wb_pkg::wb_data_t rsp_data;
    logic             rsp_err;

    pet_sys_bus u_pet_sys_bus (
        .wb_clock_i         (wb_clock_i),
        .arst_n_i           (arst_n_i),
        .cmd_valid_i        (cmd_valid_i),
        .cmd_we_i           (cmd_we_i),
        .cmd_addr_i         (cmd_addr_i),
        .cmd_data_i         (cmd_data_i),
        .rsp_valid_o        (rsp_valid_o),
        .rsp_data_o         (rsp_data_o),
        .rsp_err_o          (rsp_err_o),
        .video_graphic_i    (video_graphic_i),
        .cpu_ready_o        (cpu_ready_o),
        .cpu_reset_o        (cpu_reset_o),
        .video_col_80_mode_o(video_col_80_mode_o),
        .video_ram_mask_o   (video_ram_mask_o)
    );

    // 20 ns clock
    initial begin
        wb_clock_i = 1'b0;
        forever #10 wb_clock_i = ~wb_clock_i;
    end

    // Watchdog on the whole run
    initial begin
        cycle_count = 0;
        while (cycle_count <= CYCLE_LIMIT) begin
            @(posedge wb_clock_i);
            cycle_count++;
        end
        $display("Run stopped: still busy after %0d clock cycles", cycle_count);
        $display("TEST FAIL");
        $finish;
    end

    task automatic check_value(input string signal, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0d ns: %s is 0x%0h, expected 0x%0h",
                     $time, signal, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_pins(input logic [4:0] pins);
        check_value("cpu_ready_o", 32'(cpu_ready_o), 32'(pins[4]));
        check_value("cpu_reset_o", 32'(cpu_reset_o), 32'(pins[3]));
        check_value("video_col_80_mode_o", 32'(video_col_80_mode_o), 32'(pins[2]));
        check_value("video_ram_mask_o", 32'(video_ram_mask_o), 32'(pins[1:0]));
    endtask

    task automatic record_result(input int number, input string name);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("Test %0d (%s): passed", number, name);
        end else begin
            tests_failed++;
            $display("Test %0d (%s): failed", number, name);
        end
    endtask

    task automatic add_step(input string name, input logic we, input wb_pkg::wb_addr_t addr,
                            input wb_pkg::wb_data_t data, input logic graphic,
                            input logic chk_data, input wb_pkg::wb_data_t exp_data,
                            input logic exp_err, input logic [4:0] exp_pins);
        steps[step_count] = {we, addr, data, graphic, chk_data, exp_data, exp_err, exp_pins};
        step_names[step_count] = name;
        step_count++;
    endtask

    task automatic build_table();
        step_count  = 0;
        ram_addr[0] = 8'h00;
        ram_addr[1] = 8'h15;
        ram_addr[2] = 8'h2a;
        ram_addr[3] = 8'h3f;
        // RAM: a write returns old contents, unknown here
        for (int i = 0; i < 4; i++) begin
            ram_data[i] = 8'($random(seed));
            add_step("ram write", 1'b1, ram_addr[i], ram_data[i], 1'b0,
                     1'b0, 8'h00, 1'b0, PINS_RESET);
        end
        for (int i = 0; i < 4; i++) begin
            add_step("ram read", 1'b0, ram_addr[i], 8'h00, 1'b0,
                     1'b1, ram_data[i], 1'b0, PINS_RESET);
        end
        // CPU register, write returns the power-on value
        add_step("cpu write", 1'b1, 8'h80, 8'h01, 1'b0, 1'b1, 8'h02, 1'b0, PINS_CPU);
        add_step("cpu read", 1'b0, 8'h80, 8'h00, 1'b0, 1'b1, 8'h01, 1'b0, PINS_CPU);
        // Video register, graphics bit always follows the input level
        add_step("video write", 1'b1, 8'h81, 8'h0d, 1'b1, 1'b1, 8'h02, 1'b0, PINS_VID_A);
        add_step("video read g1", 1'b0, 8'h81, 8'h00, 1'b1, 1'b1, 8'h0f, 1'b0, PINS_VID_A);
        add_step("video read g0", 1'b0, 8'h81, 8'h00, 1'b0, 1'b1, 8'h0d, 1'b0, PINS_VID_A);
        add_step("video rewrite", 1'b1, 8'h81, 8'h06, 1'b0, 1'b1, 8'h0d, 1'b0, PINS_VID_B);
        add_step("video read g0", 1'b0, 8'h81, 8'h00, 1'b0, 1'b1, 8'h04, 1'b0, PINS_VID_B);
        // Unmapped, 0x40 aliases RAM word 0 in its low bits
        add_step("unmapped write", 1'b1, 8'h40, 8'ha5, 1'b0, 1'b1, 8'h00, 1'b1, PINS_VID_B);
        add_step("unmapped read", 1'b0, 8'h40, 8'h00, 1'b0, 1'b1, 8'h00, 1'b1, PINS_VID_B);
        add_step("unmapped write", 1'b1, 8'h82, 8'hff, 1'b0, 1'b1, 8'h00, 1'b1, PINS_VID_B);
        add_step("unmapped read", 1'b0, 8'hc0, 8'h00, 1'b0, 1'b1, 8'h00, 1'b1, PINS_VID_B);
        // Contents left alone by the failed cycles
        add_step("cpu read", 1'b0, 8'h80, 8'h00, 1'b0, 1'b1, 8'h01, 1'b0, PINS_VID_B);
        add_step("video read g1", 1'b0, 8'h81, 8'h00, 1'b1, 1'b1, 8'h06, 1'b0, PINS_VID_B);
        add_step("ram read", 1'b0, ram_addr[0], 8'h00, 1'b1, 1'b1, ram_data[0], 1'b0, PINS_VID_B);
        add_step("ram read", 1'b0, ram_addr[3], 8'h00, 1'b1, 1'b1, ram_data[3], 1'b0, PINS_VID_B);
    endtask

    // One command strobe, then wait for the response, sampled on the falling edge
    task automatic run_command(input step_t st, output int unsigned cycles,
                               output logic got_rsp, output wb_pkg::wb_data_t data,
                               output logic err);
        got_rsp = 1'b0;
        data    = '0;
        err     = 1'b0;
        @(posedge wb_clock_i);
        #1;
        cmd_valid_i     = 1'b1;
        cmd_we_i        = st.we;
        cmd_addr_i      = st.addr;
        cmd_data_i      = st.data;
        video_graphic_i = st.graphic;
        @(posedge wb_clock_i);
        cycles = 1;
        #1;
        cmd_valid_i = 1'b0;
        while (!got_rsp && cycles < STEP_CYCLES) begin
            @(negedge wb_clock_i);
            if (rsp_valid_o) begin
                got_rsp = 1'b1;
                data    = rsp_data_o;
                err     = rsp_err_o;
            end else begin
                @(posedge wb_clock_i);
                cycles++;
            end
        end
    endtask

    initial begin
        // Start high so the reset line sees a falling edge
        arst_n_i        = 1'b1;
        cmd_valid_i     = 1'b0;
        cmd_we_i        = 1'b0;
        cmd_addr_i      = '0;
        cmd_data_i      = '0;
        video_graphic_i = 1'b0;
        seed            = 32'he2cf_51bb;
        error_count     = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        build_table();
        #2 arst_n_i = 1'b0;
        repeat (3) @(posedge wb_clock_i);
        #1 arst_n_i = 1'b1;

        // Power-on state of the responses and pins
        @(negedge wb_clock_i);
        errors_before = error_count;
        check_value("rsp_valid_o", 32'(rsp_valid_o), 32'd0);
        check_value("rsp_err_o", 32'(rsp_err_o), 32'd0);
        check_pins(PINS_RESET);
        record_result(0, "reset values");

        for (int s = 0; s < step_count; s++) begin
            errors_before = error_count;
            run_command(steps[s], latency, seen, rsp_data, rsp_err);
            if (!seen) begin
                $display("Step %0d: no response within %0d cycles", s + 1, STEP_CYCLES);
                error_count++;
            end else begin
                check_value("rsp_err_o", 32'(rsp_err), 32'(steps[s].exp_err));
                if (steps[s].chk_data) begin
                    check_value("rsp_data_o", 32'(rsp_data), 32'(steps[s].exp_data));
                end
                if (!steps[s].exp_err) begin
                    check_value("response latency", 32'(latency), 32'(MAPPED_LATENCY));
                end else if (latency > MAX_LATENCY) begin
                    $display("Step %0d: error response took %0d cycles, limit is %0d",
                             s + 1, latency, MAX_LATENCY);
                    error_count++;
                end
                check_pins(steps[s].exp_pins);
            end
            record_result(s + 1, step_names[s]);
        end

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d checker failures",
                 tests_passed + tests_failed, tests_passed, tests_failed,
                 u_pet_sys_bus.u_master.u_checker.fail_count);
        if (error_count == 0 && u_pet_sys_bus.u_master.u_checker.fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end
endmodule

//--- pet_sys_bus.f
+incdir+rtl
rtl/wb_pkg.sv
rtl/pet_reg_pkg.sv
rtl/wb_decode.sv
rtl/wb_timeout_timer.sv
rtl/bus_master_fsm.sv
rtl/register_file.sv
rtl/char_ram.sv
rtl/pet_sys_bus.sv
sim/pet_sys_bus_checker.sv
sim/pet_sys_bus_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := pet_sys_bus_tb
FILELIST  := pet_sys_bus.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := TEST PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
